// File: bht.sv
module bht import bpred_pkg::*; #(
  parameter int INDEX_BITS = 4                    // Table holds 2**INDEX_BITS counters
) (
  input  logic     clk,                           // Core clock
  input  logic     reset,                         // Synchronous, active high
  input  logic     stall,                         // Blocks counter updates
  input  pc_t      fetch_pc,                      // Address being fetched
  input  logic     resolve_valid,                 // One cycle resolve pulse
  input  resolve_t resolve,                       // Outcome from decode
  output ctr_t     bht_ctr                        // Counter for fetch_pc
);

  logic [INDEX_BITS-1:0] rd_idx;                  // Fetch side index
  logic [INDEX_BITS-1:0] wr_idx;                  // Resolve side index
  ctr_t                  ctr_next;                // Counter after the update

  ////////////////////////////////////////////////////////////
  // Indexing
  ////////////////////////////////////////////////////////////
  // Bit 0 is always zero for 2-byte instructions
  assign rd_idx = fetch_pc[INDEX_BITS:1];         // Skip the byte offset
  assign wr_idx = resolve.pc[INDEX_BITS:1];       // Same slice on resolve side

  ////////////////////////////////////////////////////////////
  // Saturating update
  ////////////////////////////////////////////////////////////
  // Starts from the counter fetch saw, not the one in the table now
  always_comb begin
    ctr_next = resolve.pred_ctr;                  // Hold by default
    case (resolve.pred_ctr)
      2'd0: ctr_next = resolve.actual_taken ? 2'd1 : CTR_MIN; // Strong not taken
      2'd1: ctr_next = resolve.actual_taken ? 2'd2 : 2'd0;    // Weak not taken
      2'd2: ctr_next = resolve.actual_taken ? 2'd3 : 2'd1;    // Weak taken
      2'd3: ctr_next = resolve.actual_taken ? CTR_MAX : 2'd2; // Strong taken
      default: ctr_next = CTR_RESET;              // Unknown input falls back to reset
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counter storage
  ////////////////////////////////////////////////////////////
  pred_table #(
    .INDEX_BITS (INDEX_BITS),
    .entry_t    (ctr_t),
    .RESET_VAL  (CTR_RESET)
  ) i_table (
    .clk   (clk),
    .reset (reset),
    .stall (stall),
    .wen   (resolve_valid),                       // Every resolve trains the counter
    .waddr (wr_idx),
    .raddr (rd_idx),
    .wdata (ctr_next),
    .rdata (bht_ctr)
  );

endmodule

// File: bpred_pkg.sv
package bpred_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and scalar types
  ////////////////////////////////////////////////////////////
  localparam int PC_W = 16;                 // Byte address width of the core

  typedef logic [PC_W-1:0] pc_t;            // Fetch or branch address
  typedef logic [1:0]      ctr_t;           // 2-bit saturating direction counter

  localparam ctr_t CTR_RESET = 2'd0;        // Strong not taken after reset
  localparam ctr_t CTR_MAX   = 2'd3;        // Strong taken
  localparam ctr_t CTR_MIN   = 2'd0;        // Strong not taken

  ////////////////////////////////////////////////////////////
  // Table entries
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic valid;                            // Entry holds a trained target
    pc_t  branch_pc;                        // Full branch PC kept as tag
    pc_t  target;                           // Taken target of that branch
  } btb_entry_t;

  localparam btb_entry_t BTB_RESET = '0;    // Invalid, zero tag and target

  ////////////////////////////////////////////////////////////
  // Fetch side and decode side bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic taken;                            // Predicted direction
    ctr_t ctr;                              // Counter seen at fetch
    logic btb_hit;                          // Tag matched in the btb
    pc_t  next_pc;                          // Predicted next fetch address
  } fetch_pred_t;

  // Decode hands back the outcome plus what fetch predicted for it
  typedef struct packed {
    pc_t  pc;                               // Address of the resolved branch
    logic actual_taken;                     // Real direction
    pc_t  actual_target;                    // Real target when taken
    ctr_t pred_ctr;                         // Counter carried from fetch
    pc_t  pred_next_pc;                     // Next PC fetch actually used
  } resolve_t;

endpackage

// File: branch_predictor.sv
module branch_predictor import bpred_pkg::*; #(
  parameter int INDEX_BITS = 4                    // Both tables hold 2**INDEX_BITS entries
) (
  input  logic        clk,                        // Core clock
  input  logic        reset,                      // Synchronous, active high
  input  pc_t         fetch_pc,                   // From fetch
  output fetch_pred_t pred,                       // To fetch, same cycle
  input  logic        resolve_valid,              // From decode
  input  resolve_t    resolve,                    // From decode
  input  logic        stall,                      // Pipeline stall level
  output logic        redirect,                   // To fetch
  output pc_t         redirect_pc                 // To fetch
);

  ctr_t bht_ctr;                                  // Direction counter lookup
  logic btb_hit;                                  // Target lookup hit
  pc_t  btb_target;                               // Target lookup data

  ////////////////////////////////////////////////////////////
  // Lookup tables
  ////////////////////////////////////////////////////////////
  bht #(.INDEX_BITS(INDEX_BITS)) i_bht (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .fetch_pc      (fetch_pc),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .bht_ctr       (bht_ctr)
  );

  btb #(.INDEX_BITS(INDEX_BITS)) i_btb (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .fetch_pc      (fetch_pc),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .btb_hit       (btb_hit),
    .btb_target    (btb_target)
  );

  ////////////////////////////////////////////////////////////
  // Next PC and redirect
  ////////////////////////////////////////////////////////////
  next_pc_select i_next_pc_select (
    .fetch_pc      (fetch_pc),
    .bht_ctr       (bht_ctr),
    .btb_hit       (btb_hit),
    .btb_target    (btb_target),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .pred          (pred),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

endmodule

// File: branch_predictor_props.sv
module branch_predictor_props import bpred_pkg::*; (
  input logic        clk,                         // Core clock
  input logic        reset,                       // Synchronous, active high
  input logic        stall,                       // Write block level
  input pc_t         fetch_pc,                    // Lookup address
  input fetch_pred_t pred,                        // Lookup result
  input logic        resolve_valid,               // Resolve pulse
  input logic        redirect                     // Redirect pulse
);

  ////////////////////////////////////////////////////////////
  // Redirect
  ////////////////////////////////////////////////////////////
  redirect_needs_resolve: assert property (@(posedge clk) redirect |-> resolve_valid)
    else $error("redirect high without resolve_valid");

  redirect_low_in_reset: assert property (@(posedge clk) reset |-> !redirect)
    else $error("redirect high during reset");

  ////////////////////////////////////////////////////////////
  // Stall
  ////////////////////////////////////////////////////////////
  // Blocked writes leave the lookup for a held PC unchanged
  pred_held_in_stall: assert property (@(posedge clk)
    ($past(stall) && !$past(reset) && $stable(fetch_pc)) |-> $stable(pred))
    else $error("pred changed across a stalled edge with fetch_pc held");

endmodule

bind branch_predictor branch_predictor_props i_props (
  .clk           (clk),
  .reset         (reset),
  .stall         (stall),
  .fetch_pc      (fetch_pc),
  .pred          (pred),
  .resolve_valid (resolve_valid),
  .redirect      (redirect)
);

// File: btb.sv
module btb import bpred_pkg::*; #(
  parameter int INDEX_BITS = 4                    // Table holds 2**INDEX_BITS entries
) (
  input  logic     clk,                           // Core clock
  input  logic     reset,                         // Synchronous, active high
  input  logic     stall,                         // Blocks entry updates
  input  pc_t      fetch_pc,                      // Address being fetched
  input  logic     resolve_valid,                 // One cycle resolve pulse
  input  resolve_t resolve,                       // Outcome from decode
  output logic     btb_hit,                       // Valid entry with matching tag
  output pc_t      btb_target                     // Stored target of that entry
);

  logic [INDEX_BITS-1:0] rd_idx;                  // Fetch side index
  logic [INDEX_BITS-1:0] wr_idx;                  // Resolve side index
  logic                  wr_en;                   // Taken resolve only
  btb_entry_t            rd_entry;                // Entry under fetch_pc
  btb_entry_t            wr_entry;                // Entry built from resolve

  ////////////////////////////////////////////////////////////
  // Indexing and write side
  ////////////////////////////////////////////////////////////
  assign rd_idx = fetch_pc[INDEX_BITS:1];         // Drop byte offset
  assign wr_idx = resolve.pc[INDEX_BITS:1];

  // A not-taken branch leaves any older target in place
  assign wr_en = resolve_valid && resolve.actual_taken;

  always_comb begin
    wr_entry           = BTB_RESET;
    wr_entry.valid     = 1'b1;                    // Entry becomes usable
    wr_entry.branch_pc = resolve.pc;              // Whole PC kept as tag
    wr_entry.target    = resolve.actual_target;   // Where the branch went
  end

  ////////////////////////////////////////////////////////////
  // Target storage
  ////////////////////////////////////////////////////////////
  pred_table #(
    .INDEX_BITS (INDEX_BITS),
    .entry_t    (btb_entry_t),
    .RESET_VAL  (BTB_RESET)
  ) i_table (
    .clk   (clk),
    .reset (reset),
    .stall (stall),
    .wen   (wr_en),
    .waddr (wr_idx),
    .raddr (rd_idx),
    .wdata (wr_entry),
    .rdata (rd_entry)
  );

  ////////////////////////////////////////////////////////////
  // Tag compare
  ////////////////////////////////////////////////////////////
  // Aliasing PCs share a slot but fail the full tag check
  assign btb_hit    = rd_entry.valid && (rd_entry.branch_pc == fetch_pc);
  assign btb_target = rd_entry.target;            // Only meaningful on a hit

endmodule

// File: list.f
bpred_pkg.sv
pred_table.sv
bht.sv
btb.sv
next_pc_select.sv
branch_predictor.sv
branch_predictor_props.sv
tb_branch_predictor.sv

// File: next_pc_select.sv
module next_pc_select import bpred_pkg::*; (
  input  pc_t         fetch_pc,                   // Address being fetched
  input  ctr_t        bht_ctr,                    // Counter from the bht
  input  logic        btb_hit,                    // Tag hit from the btb
  input  pc_t         btb_target,                 // Target from the btb
  input  logic        resolve_valid,              // One cycle resolve pulse
  input  resolve_t    resolve,                    // Outcome from decode
  output fetch_pred_t pred,                       // Prediction back to fetch
  output logic        redirect,                   // Flush and refetch
  output pc_t         redirect_pc                 // Correct next PC on redirect
);

  localparam pc_t PC_STEP = pc_t'(2);             // 16-bit instructions

  logic pred_taken;                               // Direction from counter MSB
  logic use_target;                               // Taken and a target is known
  pc_t  fetch_seq_pc;                             // Fall-through of fetch_pc
  pc_t  resolve_seq_pc;                           // Fall-through of resolved branch
  pc_t  correct_pc;                               // What fetch should have used

  ////////////////////////////////////////////////////////////
  // Fetch side prediction
  ////////////////////////////////////////////////////////////
  assign pred_taken   = bht_ctr[1];               // 2 and 3 mean taken
  assign fetch_seq_pc = fetch_pc + PC_STEP;

  // A taken guess without a btb hit has no target to go to
  // so fetch falls through
  assign use_target = pred_taken && btb_hit;

  always_comb begin
    pred.taken   = pred_taken;
    pred.ctr     = bht_ctr;                       // Carried down the pipe for training
    pred.btb_hit = btb_hit;
    pred.next_pc = use_target ? btb_target : fetch_seq_pc;
  end

  ////////////////////////////////////////////////////////////
  // Resolve check
  ////////////////////////////////////////////////////////////
  assign resolve_seq_pc = resolve.pc + PC_STEP;
  assign correct_pc     = resolve.actual_taken ? resolve.actual_target
                                               : resolve_seq_pc;

  // Compare the real next PC with the one fetch went to
  // This also catches a right direction with a stale target
  assign redirect    = resolve_valid && (correct_pc != resolve.pred_next_pc);
  assign redirect_pc = correct_pc;                // Valid only with redirect

endmodule

// File: pred_table.sv
module pred_table #(
  parameter int   INDEX_BITS = 4,                 // log2 of the entry count
  parameter type  entry_t    = logic [1:0],       // Payload stored per entry
  parameter entry_t RESET_VAL = '0                // Value loaded on reset
) (
  input  logic                  clk,              // Core clock
  input  logic                  reset,            // Synchronous, active high
  input  logic                  stall,            // Blocks all writes while high
  input  logic                  wen,              // Write request from resolve
  input  logic [INDEX_BITS-1:0] waddr,            // Resolve side index
  input  logic [INDEX_BITS-1:0] raddr,            // Fetch side index
  input  entry_t                wdata,            // New entry contents
  output entry_t                rdata             // Entry at raddr
);

  localparam int DEPTH = 1 << INDEX_BITS;         // Number of entries

  entry_t mem [DEPTH];                            // Register array storage
  logic   do_write;                               // Qualified write strobe

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////
  // Separate read and write indices so a lookup and an update
  // can share one cycle
  assign rdata = mem[raddr];                      // Asynchronous read

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  assign do_write = wen && !stall;                // Stall drops the update

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= RESET_VAL;                      // Whole table back to default
      end
    end else if (do_write) begin
      mem[waddr] <= wdata;                        // Visible to lookups next cycle
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_branch_predictor \
  -Mdir "$build_dir" \
  -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$log_file"; then
  echo "Run passed"
  exit 0
else
  echo "Pass line not found in $log_file"
  exit 1
fi

// File: tb_branch_predictor.sv
module tb_branch_predictor import bpred_pkg::*; ();

  localparam int INDEX_BITS = 4;                  // Same depth as the DUT instance
  localparam int DEPTH      = 1 << INDEX_BITS;    // Entries per table
  localparam int CLK_PERIOD = 8;

  logic        clk;
  logic        reset;
  pc_t         fetch_pc;
  fetch_pred_t pred;
  logic        resolve_valid;
  resolve_t    resolve;
  logic        stall;
  logic        redirect;
  pc_t         redirect_pc;

  ctr_t       m_ctr [DEPTH];                      // Model counters
  btb_entry_t m_btb [DEPTH];                      // Model target entries
  pc_t        pc_pool [16];                       // PCs of the random stream
  pc_t        target_pool [16];                   // Usual target per pooled PC

  int  seed;                                      // $random state
  bit  waiting;                                   // A clock wait is in progress
  time wait_deadline;                             // Latest time that wait may end

  branch_predictor #(.INDEX_BITS(INDEX_BITS)) i_dut (
    .clk           (clk),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .pred          (pred),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .stall         (stall),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Fires when the current wait outlives its own cycle limit
  initial begin : watchdog
    while (!(waiting && ($time > wait_deadline))) begin
      #1;
    end
    $display("A wait for the clock ran past its cycle limit");
    stop_with_failure();
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic int idx_of(input pc_t pc);
    return int'(pc[INDEX_BITS:1]);                // Byte offset dropped
  endfunction

  function automatic ctr_t trained_ctr(input ctr_t ctr, input logic taken);
    ctr_t result;
    result = ctr;
    if (taken && (ctr != 2'd3)) begin
      result = ctr + 2'd1;                        // Count up, stop at 3
    end else if (!taken && (ctr != 2'd0)) begin
      result = ctr - 2'd1;                        // Count down, stop at 0
    end
    return result;
  endfunction

  function automatic fetch_pred_t expected_pred(input pc_t pc);
    fetch_pred_t want;
    int          idx;
    idx          = idx_of(pc);
    want.ctr     = m_ctr[idx];
    want.taken   = (m_ctr[idx] >= 2'd2);          // Upper half predicts taken
    want.btb_hit = m_btb[idx].valid && (m_btb[idx].branch_pc == pc);
    want.next_pc = (want.taken && want.btb_hit) ? m_btb[idx].target : pc + 16'd2;
    return want;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < DEPTH; i++) begin
      m_ctr[i] = 2'd0;                            // Strong not taken
      m_btb[i] = '0;
    end
  endtask

  task automatic update_model(input resolve_t r);
    int idx;
    idx        = idx_of(r.pc);
    m_ctr[idx] = trained_ctr(r.pred_ctr, r.actual_taken); // From the carried counter
    if (r.actual_taken) begin
      m_btb[idx].valid     = 1'b1;
      m_btb[idx].branch_pc = r.pc;
      m_btb[idx].target    = r.actual_target;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Waits, checks and drivers
  ////////////////////////////////////////////////////////////
  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic advance_cycles(input int n);
    wait_deadline = $time + time'((n + 1) * CLK_PERIOD); // One spare period
    waiting       = 1'b1;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
    waiting = 1'b0;
  endtask

  task automatic check_pred(input fetch_pred_t want);
    if (pred !== want) begin
      $display("ERR pred at fetch_pc %h: got %h expected %h (ctr %h/%h next_pc %h/%h)",
               fetch_pc, pred, want, pred.ctr, want.ctr, pred.next_pc, want.next_pc);
      stop_with_failure();
    end
  endtask

  task automatic check_redirect(input logic want, input pc_t want_pc);
    if (redirect !== want) begin
      $display("ERR redirect: got %h expected %h", redirect, want);
      stop_with_failure();
    end
    if (want && (redirect_pc !== want_pc)) begin
      $display("ERR redirect_pc: got %h expected %h", redirect_pc, want_pc);
      stop_with_failure();
    end
  endtask

  // Starts and ends on a falling edge
  task automatic lookup_and_check(input pc_t pc);
    fetch_pc = pc;
    #1;
    check_pred(expected_pred(pc));
    advance_cycles(1);
  endtask

  task automatic send_resolve(input resolve_t r, input logic stall_level);
    pc_t  want_pc;
    logic want;
    want_pc       = r.actual_taken ? r.actual_target : r.pc + 16'd2;
    want          = (want_pc != r.pred_next_pc);  // Redirect on any wrong next PC
    resolve_valid = 1'b1;
    resolve       = r;
    stall         = stall_level;
    #1;
    check_redirect(want, want_pc);                // Same cycle as the pulse
    advance_cycles(1);
    resolve_valid = 1'b0;
    resolve       = '0;
    stall         = 1'b0;
    if (!stall_level) begin
      update_model(r);                            // Stalled resolves are lost
    end
  endtask

  // Resolve carrying what fetch predicted for this PC
  task automatic send_branch(input pc_t pc, input logic taken, input pc_t target,
                             input logic stall_level);
    resolve_t    r;
    fetch_pred_t seen;
    seen            = expected_pred(pc);
    r.pc            = pc;
    r.actual_taken  = taken;
    r.actual_target = target;
    r.pred_ctr      = seen.ctr;
    r.pred_next_pc  = seen.next_pc;
    send_resolve(r, stall_level);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic after_reset_lookups();
    for (int i = 0; i < 32; i++) begin
      lookup_and_check(pc_t'(i * 2));             // Low PCs, every index twice
      lookup_and_check(16'hF000 + pc_t'(i * 2));  // High PCs
    end
  endtask

  task automatic counter_training();
    pc_t pc;
    pc = 16'h0040;
    for (int i = 0; i < 5; i++) begin
      send_branch(pc, 1'b1, 16'h0100, 1'b0);      // 1 2 3 then stays at 3
      lookup_and_check(pc);
    end
    for (int i = 0; i < 5; i++) begin
      send_branch(pc, 1'b0, 16'h0000, 1'b0);      // 2 1 0 then stays at 0
      lookup_and_check(pc);
    end
  endtask

  task automatic target_prediction();
    pc_t pc;
    pc_t alias_pc;
    pc       = 16'h0086;
    alias_pc = 16'h00A6;                          // Same index, other tag
    send_branch(pc, 1'b1, 16'h0420, 1'b0);
    lookup_and_check(pc);                         // Hit but counter still 1
    send_branch(pc, 1'b1, 16'h0420, 1'b0);
    lookup_and_check(pc);                         // Now follows the target
    lookup_and_check(alias_pc);                   // Tag miss, falls through
  endtask

  task automatic redirect_checks();
    resolve_t    r;
    logic [31:0] rand_bits;
    for (int i = 0; i < 24; i++) begin
      rand_bits       = $random(seed);
      r.pc            = {rand_bits[15:1], 1'b0};
      r.actual_taken  = rand_bits[16];
      r.pred_ctr      = rand_bits[18:17];
      rand_bits       = $random(seed);
      r.actual_target = {rand_bits[15:1], 1'b0};
      if (rand_bits[16]) begin
        r.pred_next_pc = r.actual_taken ? r.actual_target : r.pc + 16'd2;
      end else begin
        r.pred_next_pc = {rand_bits[31:18], 2'b10}; // Arbitrary guess
      end
      send_resolve(r, 1'b0);
    end
  endtask

  task automatic stall_blocks_writes();
    pc_t pc;
    pc = 16'h0010;
    lookup_and_check(pc);
    send_branch(pc, 1'b1, 16'h0200, 1'b1);        // Mispredicted, so redirect
    lookup_and_check(pc);                         // Tables untouched
    send_branch(pc, 1'b1, 16'h0200, 1'b1);
    send_branch(pc, 1'b0, 16'h0000, 1'b1);
    lookup_and_check(pc);
  endtask

  task automatic random_stream();
    logic [31:0] rand_bits;
    int          k;
    pc_t         target;
    for (int i = 0; i < 16; i++) begin
      rand_bits      = $random(seed);
      pc_pool[i]     = {8'h00, rand_bits[7:1], 1'b0}; // Small range forces aliasing
      target_pool[i] = {rand_bits[31:17], 1'b0};
    end
    for (int i = 0; i < 200; i++) begin
      rand_bits = $random(seed);
      k         = int'(rand_bits[3:0]);
      target    = rand_bits[4] ? {rand_bits[31:17], 1'b0} : target_pool[k];
      lookup_and_check(pc_pool[k]);
      send_branch(pc_pool[k], rand_bits[5], target, rand_bits[8:6] == 3'd0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed          = 20;
    clk           = 1'b0;
    reset         = 1'b1;
    fetch_pc      = '0;
    resolve_valid = 1'b0;
    resolve       = '0;
    stall         = 1'b0;
    reset_model();
    advance_cycles(2);                            // Two rising edges in reset
    reset = 1'b0;
    after_reset_lookups();
    counter_training();
    target_prediction();
    redirect_checks();
    stall_blocks_writes();
    random_stream();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
